//--- rtl/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Data path and address width.
`define MIPS_XLEN 32

// General purpose register file.
`define MIPS_NREGS 32
`define MIPS_RAW 5

// First fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

`endif

//--- rtl/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

        typedef logic [`MIPS_XLEN-1:0] word_t;
        typedef logic [`MIPS_RAW-1:0]  reg_addr_t;

        typedef enum logic [2:0] {
                ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
        } alu_op_t;

        typedef enum logic [1:0] {
                MEM_NONE, MEM_LOAD, MEM_STORE
        } mem_op_t;

        typedef enum logic [1:0] {
                BR_NONE, BR_BEQ, BR_BNE
        } br_op_t;

        // Primary opcodes.
        localparam logic [5:0] OP_SPECIAL = 6'h00;
        localparam logic [5:0] OP_BEQ     = 6'h04;
        localparam logic [5:0] OP_BNE     = 6'h05;
        localparam logic [5:0] OP_ADDIU   = 6'h09;
        localparam logic [5:0] OP_ORI     = 6'h0d;
        localparam logic [5:0] OP_LUI     = 6'h0f;
        localparam logic [5:0] OP_LW      = 6'h23;
        localparam logic [5:0] OP_SW      = 6'h2b;

        // Function codes under OP_SPECIAL.
        localparam logic [5:0] FN_ADDU = 6'h21;
        localparam logic [5:0] FN_SUBU = 6'h23;
        localparam logic [5:0] FN_AND  = 6'h24;
        localparam logic [5:0] FN_OR   = 6'h25;
        localparam logic [5:0] FN_XOR  = 6'h26;
        localparam logic [5:0] FN_SLT  = 6'h2a;

        typedef struct packed {
                alu_op_t   alu_op;
                logic      use_imm;
                word_t     imm;
                mem_op_t   mem_op;
                reg_addr_t rd;
                logic      reg_we;
                word_t     rs_val;
                word_t     rt_val;
        } id_ex_t;

        typedef struct packed {
                mem_op_t   mem_op;
                reg_addr_t rd;
                logic      reg_we;
                word_t     result;
                word_t     store_data;
        } ex_mm_t;

        typedef struct packed {
                reg_addr_t rd;
                logic      reg_we;
                word_t     wdata;
        } mm_wb_t;

endpackage

//--- rtl/mips_regfile.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_regfile (
        input  logic                clk,
        input  logic                rst_n,
        input  logic                we_i,
        input  mips_pkg::reg_addr_t waddr_i,
        input  mips_pkg::word_t     wdata_i,
        input  mips_pkg::reg_addr_t raddr_s_i,
        input  mips_pkg::reg_addr_t raddr_t_i,
        output mips_pkg::word_t     rdata_s_o,
        output mips_pkg::word_t     rdata_t_o
);
        import mips_pkg::*;

        word_t regs [`MIPS_NREGS];

        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        for (int i = 0; i < `MIPS_NREGS; i++)
                                regs[i] <= '0;
                end else if (we_i && waddr_i != `MIPS_RAW'd0) begin
                        regs[waddr_i] <= wdata_i;
                end
        end

        // Old value on a same-cycle read; forwarding covers the gap.
        assign rdata_s_o = regs[raddr_s_i];
        assign rdata_t_o = regs[raddr_t_i];

        zero_reg_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
                (raddr_s_i != `MIPS_RAW'd0 || rdata_s_o == '0) &&
                (raddr_t_i != `MIPS_RAW'd0 || rdata_t_o == '0));

endmodule

//--- rtl/mips_decode.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_decode (
        input  mips_pkg::word_t     inst_i,
        output mips_pkg::reg_addr_t rs_o,
        output mips_pkg::reg_addr_t rt_o,
        output mips_pkg::alu_op_t   alu_op_o,
        output logic                use_imm_o,
        output mips_pkg::word_t     imm_o,
        output mips_pkg::mem_op_t   mem_op_o,
        output mips_pkg::br_op_t    br_op_o,
        output mips_pkg::reg_addr_t rd_o,
        output logic                reg_we_o
);
        import mips_pkg::*;

        logic [5:0] opcode;
        logic [5:0] funct;
        word_t      imm_sext;
        word_t      imm_zext;

        assign opcode   = inst_i[31:26];
        assign funct    = inst_i[5:0];
        assign rs_o     = inst_i[25:21];
        assign rt_o     = inst_i[20:16];
        assign imm_sext = {{(`MIPS_XLEN-16){inst_i[15]}}, inst_i[15:0]};
        assign imm_zext = {{(`MIPS_XLEN-16){1'b0}}, inst_i[15:0]};

        // I-type defaults; anything unrecognised falls through as a bubble.
        always_comb begin
                alu_op_o  = ALU_ADD;
                use_imm_o = 1'b1;
                imm_o     = imm_sext;
                mem_op_o  = MEM_NONE;
                br_op_o   = BR_NONE;
                rd_o      = inst_i[20:16];
                reg_we_o  = 1'b0;
                case (opcode)
                OP_SPECIAL: begin
                        use_imm_o = 1'b0;
                        rd_o      = inst_i[15:11];
                        reg_we_o  = 1'b1;
                        case (funct)
                        FN_ADDU: alu_op_o = ALU_ADD;
                        FN_SUBU: alu_op_o = ALU_SUB;
                        FN_AND:  alu_op_o = ALU_AND;
                        FN_OR:   alu_op_o = ALU_OR;
                        FN_XOR:  alu_op_o = ALU_XOR;
                        FN_SLT:  alu_op_o = ALU_SLT;
                        default: reg_we_o = 1'b0;
                        endcase
                end
                OP_ADDIU: reg_we_o = 1'b1;
                OP_ORI: begin
                        alu_op_o = ALU_OR;
                        imm_o    = imm_zext;
                        reg_we_o = 1'b1;
                end
                OP_LUI: begin
                        alu_op_o = ALU_LUI;
                        imm_o    = {inst_i[15:0], {(`MIPS_XLEN-16){1'b0}}};
                        reg_we_o = 1'b1;
                end
                OP_LW: begin
                        mem_op_o = MEM_LOAD;
                        reg_we_o = 1'b1;
                end
                OP_SW:   mem_op_o = MEM_STORE;
                OP_BEQ:  br_op_o = BR_BEQ;
                OP_BNE:  br_op_o = BR_BNE;
                default: reg_we_o = 1'b0;
                endcase
        end

endmodule

//--- rtl/mips_hazard.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_hazard (
        input  mips_pkg::reg_addr_t id_rs_i,
        input  mips_pkg::reg_addr_t id_rt_i,
        input  mips_pkg::word_t     rf_s_i,
        input  mips_pkg::word_t     rf_t_i,
        input  mips_pkg::br_op_t    br_op_i,
        input  mips_pkg::reg_addr_t ex_rd_i,
        input  logic                ex_reg_we_i,
        input  mips_pkg::mem_op_t   ex_mem_op_i,
        input  mips_pkg::word_t     ex_result_i,
        input  mips_pkg::reg_addr_t mm_rd_i,
        input  logic                mm_reg_we_i,
        input  mips_pkg::word_t     mm_value_i,
        input  mips_pkg::reg_addr_t wb_rd_i,
        input  logic                wb_reg_we_i,
        input  mips_pkg::word_t     wb_data_i,
        input  logic                ibus_stall_i,
        input  logic                dbus_stall_i,
        output mips_pkg::word_t     rs_val_o,
        output mips_pkg::word_t     rt_val_o,
        output logic                taken_o,
        output logic                en_pc_o,
        output logic                en_ifid_o,
        output logic                en_idex_o,
        output logic                en_exmm_o,
        output logic                en_mmwb_o
);
        import mips_pkg::*;

        logic load_use;

        // Youngest producer wins; a load in execute has no data yet.
        function automatic word_t fwd_value(input reg_addr_t addr, input word_t rf_val);
                word_t val;
                val = rf_val;
                if (addr == `MIPS_RAW'd0)
                        val = rf_val;
                else if (ex_reg_we_i && ex_rd_i == addr && ex_mem_op_i != MEM_LOAD)
                        val = ex_result_i;
                else if (mm_reg_we_i && mm_rd_i == addr)
                        val = mm_value_i;
                else if (wb_reg_we_i && wb_rd_i == addr)
                        val = wb_data_i;
                return val;
        endfunction

        always_comb begin
                rs_val_o = fwd_value(id_rs_i, rf_s_i);
                rt_val_o = fwd_value(id_rt_i, rf_t_i);
                case (br_op_i)
                BR_BEQ:  taken_o = rs_val_o == rt_val_o;
                BR_BNE:  taken_o = rs_val_o != rt_val_o;
                default: taken_o = 1'b0;
                endcase
        end

        assign load_use = ex_reg_we_i && ex_mem_op_i == MEM_LOAD && ex_rd_i != `MIPS_RAW'd0 &&
                          (ex_rd_i == id_rs_i || ex_rd_i == id_rt_i);

        always_comb begin
                if (dbus_stall_i)
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00000;
                else if (load_use || ibus_stall_i)
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00011;
                else
                        {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b11111;
        end

endmodule

//--- rtl/mips_alu.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_alu (
        input  mips_pkg::alu_op_t op_i,
        input  mips_pkg::word_t   a_i,
        input  mips_pkg::word_t   b_i,
        output mips_pkg::word_t   result_o
);
        import mips_pkg::*;

        logic lt;

        assign lt = $signed(a_i) < $signed(b_i);

        // Loads and stores use ALU_ADD, so the result doubles as the address.
        always_comb begin
                case (op_i)
                ALU_ADD: result_o = a_i + b_i;
                ALU_SUB: result_o = a_i - b_i;
                ALU_AND: result_o = a_i & b_i;
                ALU_OR:  result_o = a_i | b_i;
                ALU_XOR: result_o = a_i ^ b_i;
                ALU_SLT: result_o = {{(`MIPS_XLEN-1){1'b0}}, lt};
                // Decode has already moved the immediate to the upper half.
                ALU_LUI: result_o = b_i;
                default: result_o = a_i + b_i;
                endcase
        end

endmodule

//--- rtl/mips_pipe_reg.sv
`timescale 1ns/1ps

module mips_pipe_reg #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rst_n,
        input  logic     en_i,
        input  logic     bubble_i,
        input  payload_t d_i,
        output logic     valid_o,
        output payload_t q_o
);

        // Load, else bubble when the next stage moves on, else hold.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                        valid_o <= 1'b0;
                        q_o     <= '0;
                end else if (en_i) begin
                        valid_o <= 1'b1;
                        q_o     <= d_i;
                end else if (bubble_i) begin
                        valid_o <= 1'b0;
                        q_o     <= '0;
                end
        end

endmodule

//--- rtl/mips_core.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module mips_core (
        input  logic            clk,
        input  logic            rst_n,
        output mips_pkg::word_t ibus_addr_o,
        output logic            ibus_rd_o,
        input  mips_pkg::word_t ibus_rdata_i,
        input  logic            ibus_stall_i,
        output mips_pkg::word_t dbus_addr_o,
        output logic            dbus_rd_o,
        output logic            dbus_wr_o,
        output mips_pkg::word_t dbus_wdata_o,
        input  mips_pkg::word_t dbus_rdata_i,
        input  logic            dbus_stall_i
);
        import mips_pkg::*;

        logic      en_pc, en_ifid, en_idex, en_exmm, en_mmwb;
        logic      id_use_imm, id_reg_we, taken;
        logic      idex_valid, exmm_valid, mmwb_valid;
        word_t     pc_q, ifid_inst, id_imm, rf_s, rf_t, rs_val, rt_val, ex_result, mm_value;
        reg_addr_t id_rs, id_rt, id_rd;
        alu_op_t   id_alu_op;
        mem_op_t   id_mem_op;
        br_op_t    id_br_op;
        id_ex_t    idex_d, idex_q;
        ex_mm_t    exmm_d, exmm_q;
        mm_wb_t    mmwb_d, mmwb_q;

        // While a branch sits in decode, pc_q already points at its delay slot.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        pc_q <= `MIPS_RESET_PC;
                else if (en_pc)
                        pc_q <= taken ? pc_q + (id_imm << 2) : pc_q + `MIPS_XLEN'd4;
        end

        // An all-zero word decodes as a bubble.
        always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n)
                        ifid_inst <= '0;
                else if (en_ifid)
                        ifid_inst <= ibus_rdata_i;
                else if (en_idex)
                        ifid_inst <= '0;
        end

        assign ibus_addr_o = pc_q;
        assign ibus_rd_o   = rst_n;

        mips_decode u_decode (.inst_i(ifid_inst), .rs_o(id_rs), .rt_o(id_rt),
                .alu_op_o(id_alu_op), .use_imm_o(id_use_imm), .imm_o(id_imm),
                .mem_op_o(id_mem_op), .br_op_o(id_br_op), .rd_o(id_rd), .reg_we_o(id_reg_we));

        mips_regfile u_regfile (.clk(clk), .rst_n(rst_n),
                .we_i(mmwb_valid && mmwb_q.reg_we), .waddr_i(mmwb_q.rd), .wdata_i(mmwb_q.wdata),
                .raddr_s_i(id_rs), .raddr_t_i(id_rt), .rdata_s_o(rf_s), .rdata_t_o(rf_t));

        mips_hazard u_hazard (.id_rs_i(id_rs), .id_rt_i(id_rt), .rf_s_i(rf_s), .rf_t_i(rf_t),
                .br_op_i(id_br_op), .ex_rd_i(idex_q.rd), .ex_reg_we_i(idex_valid && idex_q.reg_we),
                .ex_mem_op_i(idex_q.mem_op), .ex_result_i(ex_result),
                .mm_rd_i(exmm_q.rd), .mm_reg_we_i(exmm_valid && exmm_q.reg_we),
                .mm_value_i(mm_value), .wb_rd_i(mmwb_q.rd),
                .wb_reg_we_i(mmwb_valid && mmwb_q.reg_we), .wb_data_i(mmwb_q.wdata),
                .ibus_stall_i(ibus_stall_i), .dbus_stall_i(dbus_stall_i),
                .rs_val_o(rs_val), .rt_val_o(rt_val), .taken_o(taken),
                .en_pc_o(en_pc), .en_ifid_o(en_ifid), .en_idex_o(en_idex),
                .en_exmm_o(en_exmm), .en_mmwb_o(en_mmwb));

        assign idex_d = '{alu_op: id_alu_op, use_imm: id_use_imm, imm: id_imm,
                          mem_op: id_mem_op, rd: id_rd, reg_we: id_reg_we,
                          rs_val: rs_val, rt_val: rt_val};

        mips_pipe_reg #(.payload_t(id_ex_t)) u_idex (.clk(clk), .rst_n(rst_n),
                .en_i(en_idex), .bubble_i(en_exmm), .d_i(idex_d),
                .valid_o(idex_valid), .q_o(idex_q));

        mips_alu u_alu (.op_i(idex_q.alu_op), .a_i(idex_q.rs_val),
                .b_i(idex_q.use_imm ? idex_q.imm : idex_q.rt_val), .result_o(ex_result));

        assign exmm_d = '{mem_op: idex_q.mem_op, rd: idex_q.rd, reg_we: idex_q.reg_we,
                          result: ex_result, store_data: idex_q.rt_val};

        mips_pipe_reg #(.payload_t(ex_mm_t)) u_exmm (.clk(clk), .rst_n(rst_n),
                .en_i(en_exmm), .bubble_i(en_mmwb), .d_i(exmm_d),
                .valid_o(exmm_valid), .q_o(exmm_q));

        // Memory stage drives the data bus straight from its register.
        assign dbus_addr_o  = exmm_q.result;
        assign dbus_wdata_o = exmm_q.store_data;
        assign dbus_rd_o    = exmm_valid && exmm_q.mem_op == MEM_LOAD;
        assign dbus_wr_o    = exmm_valid && exmm_q.mem_op == MEM_STORE;
        assign mm_value     = (exmm_q.mem_op == MEM_LOAD) ? dbus_rdata_i : exmm_q.result;
        assign mmwb_d       = '{rd: exmm_q.rd, reg_we: exmm_q.reg_we, wdata: mm_value};

        // Writeback never repeats, so it bubbles whenever it is not loaded.
        mips_pipe_reg #(.payload_t(mm_wb_t)) u_mmwb (.clk(clk), .rst_n(rst_n),
                .en_i(en_mmwb), .bubble_i(1'b1), .d_i(mmwb_d),
                .valid_o(mmwb_valid), .q_o(mmwb_q));

        pc_holds_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
                ibus_stall_i || dbus_stall_i |=> $stable(ibus_addr_o));

        stalled_store_stable: assert property (@(posedge clk) disable iff (!rst_n)
                dbus_wr_o && dbus_stall_i |=> dbus_wr_o && $stable(dbus_addr_o) &&
                $stable(dbus_wdata_o));

endmodule

//--- dv/tb_mips_core.sv
`timescale 1ns/1ps
`include "mips_defines.svh"

module tb_mips_core;

        localparam logic [5:0] OP_BEQ   = 6'h04;
        localparam logic [5:0] OP_BNE   = 6'h05;
        localparam logic [5:0] OP_ADDIU = 6'h09;
        localparam logic [5:0] OP_ORI   = 6'h0d;
        localparam logic [5:0] OP_LUI   = 6'h0f;
        localparam logic [5:0] OP_LW    = 6'h23;
        localparam logic [5:0] OP_SW    = 6'h2b;
        localparam logic [5:0] FN_ADDU  = 6'h21;
        localparam logic [5:0] FN_SUBU  = 6'h23;
        localparam logic [5:0] FN_AND   = 6'h24;
        localparam logic [5:0] FN_OR    = 6'h25;
        localparam logic [5:0] FN_XOR   = 6'h26;
        localparam logic [5:0] FN_SLT   = 6'h2a;

        logic        clk = 1'b0;
        logic        rst_n = 1'b0;
        logic        ibus_stall = 1'b0;
        logic        dbus_stall = 1'b0;
        logic [31:0] ibus_addr, ibus_rdata, dbus_addr, dbus_wdata, dbus_rdata;
        logic        ibus_rd, dbus_rd, dbus_wr;

        logic [31:0] imem [256];
        logic [31:0] dmem [256];
        logic [31:0] dmem_ref [256];
        int          wr_count [256];
        logic        done_seen = 1'b0;
        logic        stall_en = 1'b0;
        logic [31:0] lfsr_state = 32'd67827;
        int          budget = 64;
        int          errors = 0;
        int          checks = 0;

        always #5 clk = ~clk;

        mips_core DUT (
                .clk(clk), .rst_n(rst_n),
                .ibus_addr_o(ibus_addr), .ibus_rd_o(ibus_rd),
                .ibus_rdata_i(ibus_rdata), .ibus_stall_i(ibus_stall),
                .dbus_addr_o(dbus_addr), .dbus_rd_o(dbus_rd), .dbus_wr_o(dbus_wr),
                .dbus_wdata_o(dbus_wdata), .dbus_rdata_i(dbus_rdata), .dbus_stall_i(dbus_stall)
        );

        // Unused instruction words carry an undefined opcode, so they run as bubbles.
        function automatic logic [31:0] inst_fill(input logic [31:0] addr);
                return {6'h3f, addr[25:0] ^ {addr[31:26], 20'h0}};
        endfunction

        function automatic logic [31:0] data_fill(input logic [31:0] addr);
                return 32'hdead_0000 ^ addr;
        endfunction

        // Taps for x^32 + x^22 + x^2 + x + 1.
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic logic [31:0] enc_r(input logic [5:0] funct, input int rd, rs, rt);
                return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
        endfunction

        function automatic logic [31:0] enc_i(input logic [5:0] op, input int rt, rs,
                                              input logic [15:0] imm);
                return {op, 5'(rs), 5'(rt), imm};
        endfunction

        // A stalled fetch returns junk that must never be decoded.
        assign ibus_rdata = ibus_stall ? 32'hffff_ffff :
                            (ibus_addr < 32'd1024) ? imem[ibus_addr[9:2]] : inst_fill(ibus_addr);

        // Read data only shows up while the core strobes a read.
        assign dbus_rdata = dbus_rd ? dmem[dbus_addr[9:2]] : 32'h0;

        // Word 255 is the end-of-program marker.
        always @(posedge clk) begin
                if (dbus_wr && !dbus_stall) begin
                        dmem[dbus_addr[9:2]]     <= dbus_wdata;
                        wr_count[dbus_addr[9:2]] <= wr_count[dbus_addr[9:2]] + 1;
                        if (dbus_addr[9:2] == 8'd255)
                                done_seen <= 1'b1;
                end
        end

        always @(posedge clk) begin
                if (stall_en) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        ibus_stall <= lfsr_state[0];
                        lfsr_state = lfsr_step(lfsr_state);
                        dbus_stall <= lfsr_state[0];
                end else begin
                        ibus_stall <= 1'b0;
                        dbus_stall <= 1'b0;
                end
        end

        task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic emit(input logic [31:0] word);
                int idx;
                idx = 0;
                while (imem[idx] != inst_fill(32'(idx) << 2))
                        idx++;
                imem[idx] = word;
                budget += 64;
        endtask

        task automatic hold_reset();
                @(posedge clk);
                rst_n <= 1'b0;
                for (int i = 0; i < 256; i++) begin
                        imem[i]     = inst_fill(32'(i) << 2);
                        dmem[i]     = data_fill(32'(i) << 2);
                        wr_count[i] = 0;
                end
                done_seen = 1'b0;
        endtask

        task automatic release_reset();
                repeat (2) @(posedge clk);
                rst_n <= 1'b1;
        endtask

        task automatic run_program();
                release_reset();
                while (!done_seen)
                        @(posedge clk);
                @(negedge clk);
        endtask

        task automatic load_alu_program();
                emit(enc_i(OP_ADDIU, 1, 0, 16'h1234));
                emit(enc_i(OP_SW, 1, 0, 16'h0100));
                emit(enc_i(OP_ADDIU, 2, 1, 16'hfffb));
                emit(enc_i(OP_SW, 2, 0, 16'h0104));
                emit(enc_r(FN_ADDU, 3, 1, 2));
                emit(enc_i(OP_SW, 3, 0, 16'h0108));
                emit(enc_r(FN_SUBU, 4, 2, 3));
                emit(enc_i(OP_SW, 4, 0, 16'h010c));
                emit(enc_r(FN_AND, 5, 4, 3));
                emit(enc_i(OP_SW, 5, 0, 16'h0110));
                emit(enc_r(FN_OR, 6, 5, 1));
                emit(enc_i(OP_SW, 6, 0, 16'h0114));
                emit(enc_r(FN_XOR, 7, 6, 4));
                emit(enc_i(OP_SW, 7, 0, 16'h0118));
                emit(enc_r(FN_SLT, 8, 7, 1));
                emit(enc_i(OP_SW, 8, 0, 16'h011c));
                emit(enc_r(FN_SLT, 9, 1, 7));
                emit(enc_i(OP_SW, 9, 0, 16'h0120));
                emit(enc_i(OP_ORI, 10, 5, 16'h8001));
                emit(enc_i(OP_SW, 10, 0, 16'h0124));
                emit(enc_i(OP_LUI, 11, 0, 16'hbeef));
                emit(enc_i(OP_SW, 11, 0, 16'h0128));
                emit(enc_i(OP_SW, 0, 0, 16'h03fc));
        endtask

        task automatic check_alu_results();
                logic [31:0] expect_val [11];
                expect_val[0]  = 32'h0000_1234;
                expect_val[1]  = expect_val[0] + 32'hffff_fffb;
                expect_val[2]  = expect_val[0] + expect_val[1];
                expect_val[3]  = expect_val[1] - expect_val[2];
                expect_val[4]  = expect_val[3] & expect_val[2];
                expect_val[5]  = expect_val[4] | expect_val[0];
                expect_val[6]  = expect_val[5] ^ expect_val[3];
                expect_val[7]  = ($signed(expect_val[6]) < $signed(expect_val[0])) ? 32'd1 : 32'd0;
                expect_val[8]  = ($signed(expect_val[0]) < $signed(expect_val[6])) ? 32'd1 : 32'd0;
                expect_val[9]  = expect_val[4] | 32'h0000_8001;
                expect_val[10] = {16'hbeef, 16'h0000};
                for (int i = 0; i < 11; i++)
                        check_eq(dmem[64 + i], expect_val[i],
                                 $sformatf("ALU store at 0x%0h", 256 + 4 * i));
        endtask

        // Words 64 to 74 hold the ALU results, word 255 the end marker.
        task automatic check_alu_store_counts();
                for (int i = 0; i < 256; i++)
                        check_eq(wr_count[i], ((i >= 64 && i <= 74) || i == 255) ? 1 : 0,
                                 $sformatf("write count of word %0d", i));
        endtask

        task automatic test_reset_state();
                hold_reset();
                @(negedge clk);
                check_eq(ibus_addr, `MIPS_RESET_PC, "fetch address in reset");
                check_eq(ibus_rd, 1'b0, "fetch strobe in reset");
                check_eq(dbus_rd, 1'b0, "data read strobe in reset");
                check_eq(dbus_wr, 1'b0, "data write strobe in reset");
                release_reset();
                @(negedge clk);
                check_eq(ibus_addr, `MIPS_RESET_PC, "first fetch address");
                check_eq(ibus_rd, 1'b1, "fetch strobe out of reset");
                @(negedge clk);
                check_eq(ibus_addr, `MIPS_RESET_PC + 32'd4, "second fetch address");
        endtask

        task automatic test_alu_forwarding();
                hold_reset();
                load_alu_program();
                run_program();
                check_alu_results();
                check_alu_store_counts();
                dmem_ref = dmem;
        endtask

        task automatic test_load_use();
                logic [31:0] v;
                v = 32'h0000_2468;
                hold_reset();
                emit(enc_i(OP_ADDIU, 1, 0, 16'h2468));
                emit(enc_i(OP_SW, 1, 0, 16'h0200));
                emit(enc_i(OP_LW, 2, 0, 16'h0200));
                emit(enc_r(FN_ADDU, 3, 2, 1));
                emit(enc_i(OP_SW, 3, 0, 16'h0204));
                emit(enc_i(OP_LW, 4, 0, 16'h0204));
                emit(enc_i(OP_SW, 4, 0, 16'h0208));
                emit(enc_i(OP_LW, 5, 0, 16'h020c));
                emit(enc_i(OP_ADDIU, 6, 5, 16'h0001));
                emit(enc_i(OP_SW, 6, 0, 16'h0210));
                emit(enc_i(OP_SW, 0, 0, 16'h03fc));
                run_program();
                check_eq(dmem[128], v, "stored word at 0x200");
                check_eq(dmem[129], v + v, "load-use sum at 0x204");
                check_eq(dmem[130], v + v, "reloaded word at 0x208");
                check_eq(dmem[132], data_fill(32'h20c) + 32'd1,
                         "preloaded word plus one at 0x210");
        endtask

        task automatic test_branches();
                hold_reset();
                emit(enc_i(OP_ADDIU, 1, 0, 16'd5));
                emit(enc_i(OP_ADDIU, 2, 0, 16'd5));
                emit(enc_i(OP_BEQ, 2, 1, 16'd2));
                emit(enc_i(OP_SW, 1, 0, 16'h0300));
                emit(enc_i(OP_SW, 1, 0, 16'h0304));
                emit(enc_i(OP_ADDIU, 3, 0, 16'd7));
                emit(enc_i(OP_BEQ, 1, 3, 16'd2));
                emit(enc_i(OP_SW, 3, 0, 16'h0308));
                emit(enc_i(OP_SW, 3, 0, 16'h030c));
                emit(enc_i(OP_ADDIU, 4, 0, 16'd9));
                emit(enc_i(OP_BNE, 3, 4, 16'd2));
                emit(enc_i(OP_SW, 4, 0, 16'h0310));
                emit(enc_i(OP_SW, 4, 0, 16'h0314));
                emit(enc_i(OP_ADDIU, 5, 0, 16'd9));
                emit(enc_i(OP_BNE, 4, 5, 16'd2));
                emit(enc_i(OP_SW, 5, 0, 16'h0318));
                emit(enc_i(OP_SW, 5, 0, 16'h031c));
                emit(enc_i(OP_SW, 0, 0, 16'h03fc));
                run_program();
                check_eq(dmem[192], 32'd5, "BEQ taken delay slot at 0x300");
                check_eq(dmem[193], data_fill(32'h304), "BEQ taken skipped word at 0x304");
                check_eq(dmem[194], 32'd7, "BEQ not taken delay slot at 0x308");
                check_eq(dmem[195], 32'd7, "BEQ not taken fall-through at 0x30c");
                check_eq(dmem[196], 32'd9, "BNE taken delay slot at 0x310");
                check_eq(dmem[197], data_fill(32'h314), "BNE taken skipped word at 0x314");
                check_eq(dmem[198], 32'd9, "BNE not taken delay slot at 0x318");
                check_eq(dmem[199], 32'd9, "BNE not taken fall-through at 0x31c");
                check_eq(wr_count[193] + wr_count[197], 32'd0, "writes to skipped words");
        endtask

        task automatic test_bus_stalls();
                stall_en = 1'b1;
                hold_reset();
                load_alu_program();
                run_program();
                stall_en = 1'b0;
                for (int i = 0; i < 256; i++)
                        check_eq(dmem[i], dmem_ref[i], $sformatf("stalled run word %0d", i));
                check_alu_store_counts();
        endtask

        initial begin
                test_reset_state();
                test_alu_forwarding();
                test_load_use();
                test_branches();
                test_bus_stalls();
                $display("Finished with %0d errors in %0d checks", errors, checks);
                if (errors == 0)
                        $display("STATUS: PASS");
                else
                        $display("STATUS: FAIL");
                $finish;
        end

        // The budget grows by 64 cycles with every instruction loaded.
        initial begin
                int waited;
                waited = 0;
                while (waited < budget) begin
                        @(posedge clk);
                        waited++;
                end
                $display("Timeout: no program reached its end marker within %0d cycles", budget);
                $display("Finished with %0d errors in %0d checks", errors, checks);
                $display("STATUS: FAIL");
                $finish;
        end

endmodule

//--- tb.f
+incdir+rtl
rtl/mips_pkg.sv
rtl/mips_regfile.sv
rtl/mips_decode.sv
rtl/mips_hazard.sv
rtl/mips_alu.sv
rtl/mips_pipe_reg.sv
rtl/mips_core.sv
dv/tb_mips_core.sv

//--- Bender.yml
package:
  name: mips_core

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/mips_regfile.sv
      - rtl/mips_decode.sv
      - rtl/mips_hazard.sv
      - rtl/mips_alu.sv
      - rtl/mips_pipe_reg.sv
      - rtl/mips_core.sv
  - target: simulation
    files:
      - dv/tb_mips_core.sv
